//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dot_product
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/approx_mult_xsyw.sv
`default_nettype none
`timescale 1ns/1ns

module approx_mult_xsyw (
    input  wire mac_pkg::operand_t x,
    input  wire mac_pkg::operand_t y,
    output mac_pkg::product_t      z
);

    // Row i holds the Baugh-Wooley partial product of x bit i-1
    logic [16:1][15:0] part;
    logic [31:0]       upper_sum;
    logic [20:0]       new_part1;
    logic [20:0]       new_part2;
    logic [20:0]       new_part3;
    logic [20:0]       new_part4;
    logic [20:0]       new_part5;

    // **********************************************************
    // Partial product rows
    // **********************************************************

    always_comb begin
        for (int i = 1; i <= 15; i++) begin
            part[i] = {~(y[15] & x[i-1]), y[14:0] & {15{x[i-1]}}};
        end
        // Sign row has inverted magnitude bits
        part[16] = {y[15] & x[15], ~(y[14:0] & {15{x[15]}})};
    end

    // Exact rows for x bits 6 to 15
    always_comb begin
        // Constant one of the sign row lands on bit 31
        upper_sum = 32'h8000_0000;
        for (int i = 7; i <= 15; i++) begin
            upper_sum = upper_sum + ({16'b0, part[i]} << (i - 1));
        end
        upper_sum = upper_sum + ({16'b0, part[16]} << 15);
    end

    // **********************************************************
    // Correction words replacing rows 1 to 6
    // **********************************************************

    always_comb begin
        new_part1     = '0;
        new_part1[1]  = part[1][1] ^ part[2][0];
        new_part1[3]  = part[1][3] ^ part[2][2];
        new_part1[7]  = part[1][7] ^ part[2][6];
        new_part1[8]  = part[5][3] & part[6][2];
        new_part1[9]  = part[3][6] & part[4][5];
        new_part1[10] = part[5][5] & part[6][4];
        new_part1[11] = part[3][9] ^ part[4][8];
        new_part1[12] = part[1][11] & part[2][10];
        new_part1[13] = part[3][11] ^ part[4][10];
        new_part1[17] = part[2][15];
        new_part1[18] = part[3][15] & part[4][14];
        new_part1[19] = part[5][14] & part[6][13];
        new_part1[20] = part[5][15] & part[6][14];
    end

    always_comb begin
        new_part2     = '0;
        new_part2[9]  = part[3][7] ^ part[4][6];
        new_part2[11] = part[5][6] & part[6][5];
        new_part2[12] = part[1][12] ^ part[2][11];
        new_part2[17] = part[5][12] & part[6][11];
        new_part2[18] = part[3][15] | part[4][14];
        new_part2[19] = part[5][15] ^ part[6][14];
        new_part2[20] = part[6][15];
    end

    // Sparse upper-column terms
    always_comb begin
        new_part3     = '0;
        new_part3[17] = part[5][12] | part[6][11];
        new_part3[18] = part[4][15];

        new_part4     = '0;
        new_part4[17] = part[5][13] ^ part[6][12];
        new_part4[18] = part[5][13] & part[6][12];

        new_part5     = '0;
        new_part5[18] = part[5][14] ^ part[6][13];
    end

    assign z = upper_sum
             + {11'b0, new_part1}
             + {11'b0, new_part2}
             + {11'b0, new_part3}
             + {11'b0, new_part4}
             + {11'b0, new_part5};

endmodule

`default_nettype wire

//--- hdl/dot_product_top.sv
`default_nettype none
`timescale 1ns/1ns

module dot_product_top (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 cfg_we,
    input  wire [mac_pkg::CFG_ADDR_W-1:0]       cfg_addr,
    input  wire [mac_pkg::CFG_DATA_W-1:0]       cfg_wdata,
    output logic [mac_pkg::CFG_DATA_W-1:0]      cfg_rdata,
    input  wire                                 sample_valid,
    input  wire mac_pkg::operand_t              a,
    input  wire mac_pkg::operand_t              b,
    output mac_pkg::acc_t                       result,
    output logic                                result_valid
);

    logic              approx_en;
    mac_pkg::count_t   sample_count;
    mac_pkg::operand_t mult_a;
    mac_pkg::operand_t mult_b;
    mac_pkg::product_t mult_z;

    // Mode and length registers
    mac_cfg_regs i_mac_cfg_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .approx_en    (approx_en),
        .sample_count (sample_count)
    );

    mac_datapath i_mac_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .a            (a),
        .b            (b),
        .approx_en    (approx_en),
        .sample_count (sample_count),
        .mult_a       (mult_a),
        .mult_b       (mult_b),
        .mult_z       (mult_z),
        .result       (result),
        .result_valid (result_valid)
    );

    // Zero-latency approximate product read back in stage 2
    approx_mult_xsyw i_approx_mult_xsyw (
        .x (mult_a),
        .y (mult_b),
        .z (mult_z)
    );

endmodule

`default_nettype wire

//--- hdl/mac_cfg_regs.sv
`default_nettype none
`timescale 1ns/1ns

module mac_cfg_regs (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 cfg_we,
    input  wire [mac_pkg::CFG_ADDR_W-1:0]       cfg_addr,
    input  wire [mac_pkg::CFG_DATA_W-1:0]       cfg_wdata,
    output logic [mac_pkg::CFG_DATA_W-1:0]      cfg_rdata,
    output logic                                approx_en,
    output mac_pkg::count_t                     sample_count
);

    // Register writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            approx_en    <= 1'b0;
            sample_count <= mac_pkg::COUNT_RESET;
        end else if (cfg_we) begin
            case (cfg_addr)
                mac_pkg::ADDR_MODE: begin
                    approx_en <= cfg_wdata[0];
                end
                mac_pkg::ADDR_COUNT: begin
                    sample_count <= mac_pkg::count_t'(cfg_wdata);
                end
                default: begin
                end
            endcase
        end
    end

    // Readback
    always_comb begin
        case (cfg_addr)
            mac_pkg::ADDR_MODE: begin
                cfg_rdata = {{(mac_pkg::CFG_DATA_W-1){1'b0}}, approx_en};
            end
            mac_pkg::ADDR_COUNT: begin
                cfg_rdata = mac_pkg::CFG_DATA_W'(sample_count);
            end
            default: begin
                cfg_rdata = '0;
            end
        endcase
    end

    // A zero length would let the datapath counter run a full 256 samples
    a_count_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        sample_count != '0
    ) else $error("sample_count written as zero");

endmodule

`default_nettype wire

//--- hdl/mac_datapath.sv
`default_nettype none
`timescale 1ns/1ns

module mac_datapath (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         sample_valid,
    input  wire mac_pkg::operand_t      a,
    input  wire mac_pkg::operand_t      b,
    input  wire                         approx_en,
    input  wire mac_pkg::count_t        sample_count,
    output mac_pkg::operand_t           mult_a,
    output mac_pkg::operand_t           mult_b,
    input  wire mac_pkg::product_t      mult_z,
    output mac_pkg::acc_t               result,
    output logic                        result_valid
);

    mac_pkg::count_t   sample_cnt;
    logic              last_sample;
    logic              s1_valid;
    logic              s1_last;
    logic              s1_approx;
    mac_pkg::operand_t s1_a;
    mac_pkg::operand_t s1_b;
    mac_pkg::product_t exact_product;
    logic              s2_valid;
    logic              s2_last;
    mac_pkg::product_t s2_product;
    mac_pkg::acc_t     product_ext;
    mac_pkg::acc_t     acc;
    mac_pkg::acc_t     acc_sum;

    // **********************************************************
    // Stage 1 captures operands and counts the group
    // **********************************************************

    assign last_sample = (sample_cnt == mac_pkg::count_t'(sample_count - 1'b1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            s1_last    <= 1'b0;
            s1_approx  <= 1'b0;
            sample_cnt <= '0;
        end else begin
            s1_valid <= sample_valid;
            if (sample_valid) begin
                s1_last    <= last_sample;
                s1_approx  <= approx_en;
                sample_cnt <= last_sample ? '0 : sample_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            s1_a <= a;
            s1_b <= b;
        end
    end

    assign mult_a = s1_a;
    assign mult_b = s1_b;

    // **********************************************************
    // Stage 2 selects the product
    // **********************************************************

    assign exact_product = s1_a * s1_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
            s2_last  <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            s2_last  <= s1_valid & s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_product <= s1_approx ? mult_z : exact_product;
        end
    end

    // **********************************************************
    // Stage 3 accumulates
    // **********************************************************

    assign product_ext = {{(mac_pkg::ACC_W-mac_pkg::PRODUCT_W){s2_product[mac_pkg::PRODUCT_W-1]}},
                          s2_product};
    assign acc_sum     = acc + product_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= s2_valid & s2_last;
            if (s2_valid) begin
                // Next product after a closed group starts from zero
                acc <= s2_last ? '0 : acc_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid && s2_last) begin
            result <= acc_sum;
        end
    end

    // Every result closes a group whose last sample came in three cycles back
    a_result_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid |-> $past(sample_valid, 3)
    ) else $error("result_valid without a matching sample");

    a_s1_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        s1_valid |-> !$isunknown({s1_a, s1_b, s1_approx, s1_last})
    ) else $error("unknown operands in stage 1");

    a_s2_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        s2_valid |-> !$isunknown({s2_product, s2_last})
    ) else $error("unknown product in stage 2");

endmodule

`default_nettype wire

//--- hdl/mac_pkg.sv
`default_nettype none

package mac_pkg;

    // **********************************************************
    // Datapath widths
    // **********************************************************

    localparam int OPERAND_W = 16;
    localparam int PRODUCT_W = 32;
    // 8 guard bits leave room for 255 full-scale products
    localparam int ACC_W     = 40;
    localparam int COUNT_W   = 8;

    typedef logic signed [OPERAND_W-1:0] operand_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;
    typedef logic signed [ACC_W-1:0]     acc_t;
    typedef logic        [COUNT_W-1:0]   count_t;

    // **********************************************************
    // Register map
    // **********************************************************

    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 8;

    // Bit 0 selects the multiplier and 1 means approximate
    localparam logic [CFG_ADDR_W-1:0] ADDR_MODE  = 2'd0;
    // Samples per dot product
    localparam logic [CFG_ADDR_W-1:0] ADDR_COUNT = 2'd1;

    localparam count_t COUNT_RESET = 8'd1;

endpackage

`default_nettype wire

//--- src.f
+incdir+verification
hdl/mac_pkg.sv
hdl/approx_mult_xsyw.sv
hdl/mac_cfg_regs.sv
hdl/mac_datapath.sv
hdl/dot_product_top.sv
verification/tb_dot_product.sv

//--- verification/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// **********************************************************
// Reference model for the dot-product engine
// **********************************************************

// Bit col of the Baugh-Wooley row that belongs to x bit row-1
function automatic logic pp_bit(input mac_pkg::operand_t x, input mac_pkg::operand_t y,
                                input int row, input int col);
    logic [3:0] xi;
    logic [3:0] yi;
    logic       and_bit;
    xi = 4'(row - 1);
    yi = 4'(col);
    and_bit = x[xi] & y[yi];
    // Sign row inverts the magnitude bits
    if (row == 16) begin
        return (col == 15) ? and_bit : ~and_bit;
    end
    return (col == 15) ? ~and_bit : and_bit;
endfunction

function automatic mac_pkg::product_t approx_product(input mac_pkg::operand_t x,
                                                    input mac_pkg::operand_t y);
    longint sum;
    sum = longint'(1) << 31;
    // Exact rows for x bits 6 to 15
    for (int r = 7; r <= 16; r++) begin
        for (int c = 0; c <= 15; c++) begin
            sum += longint'(pp_bit(x, y, r, c)) << (r - 1 + c);
        end
    end
    // Correction terms for the low six rows in column order
    sum += longint'(pp_bit(x, y, 1, 1) ^ pp_bit(x, y, 2, 0)) << 1;
    sum += longint'(pp_bit(x, y, 1, 3) ^ pp_bit(x, y, 2, 2)) << 3;
    sum += longint'(pp_bit(x, y, 1, 7) ^ pp_bit(x, y, 2, 6)) << 7;
    sum += longint'(pp_bit(x, y, 5, 3) & pp_bit(x, y, 6, 2)) << 8;
    sum += longint'(pp_bit(x, y, 3, 6) & pp_bit(x, y, 4, 5)) << 9;
    sum += longint'(pp_bit(x, y, 3, 7) ^ pp_bit(x, y, 4, 6)) << 9;
    sum += longint'(pp_bit(x, y, 5, 5) & pp_bit(x, y, 6, 4)) << 10;
    sum += longint'(pp_bit(x, y, 3, 9) ^ pp_bit(x, y, 4, 8)) << 11;
    sum += longint'(pp_bit(x, y, 5, 6) & pp_bit(x, y, 6, 5)) << 11;
    sum += longint'(pp_bit(x, y, 1, 11) & pp_bit(x, y, 2, 10)) << 12;
    sum += longint'(pp_bit(x, y, 1, 12) ^ pp_bit(x, y, 2, 11)) << 12;
    sum += longint'(pp_bit(x, y, 3, 11) ^ pp_bit(x, y, 4, 10)) << 13;
    sum += longint'(pp_bit(x, y, 2, 15)) << 17;
    sum += longint'(pp_bit(x, y, 5, 12) & pp_bit(x, y, 6, 11)) << 17;
    sum += longint'(pp_bit(x, y, 5, 12) | pp_bit(x, y, 6, 11)) << 17;
    sum += longint'(pp_bit(x, y, 5, 13) ^ pp_bit(x, y, 6, 12)) << 17;
    sum += longint'(pp_bit(x, y, 3, 15) & pp_bit(x, y, 4, 14)) << 18;
    sum += longint'(pp_bit(x, y, 3, 15) | pp_bit(x, y, 4, 14)) << 18;
    sum += longint'(pp_bit(x, y, 4, 15)) << 18;
    sum += longint'(pp_bit(x, y, 5, 13) & pp_bit(x, y, 6, 12)) << 18;
    sum += longint'(pp_bit(x, y, 5, 14) ^ pp_bit(x, y, 6, 13)) << 18;
    sum += longint'(pp_bit(x, y, 5, 14) & pp_bit(x, y, 6, 13)) << 19;
    sum += longint'(pp_bit(x, y, 5, 15) ^ pp_bit(x, y, 6, 14)) << 19;
    sum += longint'(pp_bit(x, y, 5, 15) & pp_bit(x, y, 6, 14)) << 20;
    sum += longint'(pp_bit(x, y, 6, 15)) << 20;
    return sum[31:0];
endfunction

function automatic mac_pkg::product_t exact_product(input mac_pkg::operand_t x,
                                                   input mac_pkg::operand_t y);
    longint p;
    p = longint'(x) * longint'(y);
    return p[31:0];
endfunction

// Running dot product advanced by one sample
function automatic mac_pkg::acc_t dot_step(input mac_pkg::acc_t acc, input mac_pkg::operand_t x,
                                           input mac_pkg::operand_t y, input logic approx);
    mac_pkg::product_t p;
    p = approx ? approx_product(x, y) : exact_product(x, y);
    return acc + {{8{p[31]}}, p};
endfunction

`endif

//--- verification/tb_dot_product.sv
`default_nettype none
`timescale 1ns/1ns

module tb_dot_product;

    // Samples and groups over all tests
    localparam int TOTAL_SAMPLES = 32 + 32 + 20 + 32 + 263 + 1;
    localparam int TOTAL_GROUPS  = 8 + 8 + 20 + 32 + 3 + 1;
    localparam int CYCLE_LIMIT   = TOTAL_SAMPLES + 3 * TOTAL_GROUPS + 100;

    logic                           clk;
    logic                           rst_n;
    logic                           cfg_we;
    logic [mac_pkg::CFG_ADDR_W-1:0] cfg_addr;
    logic [mac_pkg::CFG_DATA_W-1:0] cfg_wdata;
    logic [mac_pkg::CFG_DATA_W-1:0] cfg_rdata;
    logic                           sample_valid;
    mac_pkg::operand_t              a;
    mac_pkg::operand_t              b;
    mac_pkg::acc_t                  result;
    logic                           result_valid;

    int            seed = 32'h964e;
    int            checks = 0;
    int            errors = 0;
    int            mark_checks = 0;
    int            mark_errors = 0;
    int            cycles = 0;
    logic          cur_approx = 1'b0;
    mac_pkg::acc_t run_sum = '0;
    mac_pkg::acc_t expected;
    mac_pkg::acc_t expected_q[$];

    `include "tb_ref_model.svh"

    dot_product_top i_dot_product_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .sample_valid (sample_valid),
        .a            (a),
        .b            (b),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // **********************************************************
    // Result checking and run limit
    // **********************************************************

    // Results come back in group order
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            checks++;
            assert (expected_q.size() != 0) else begin
                $display("Result %0d at %0t arrived with no group pending", result, $time);
                errors++;
            end
            if (expected_q.size() != 0) begin
                expected = expected_q.pop_front();
                assert (result === expected) else begin
                    $display("MISMATCH at %0t: result %0d, expected %0d", $time, result, expected);
                    errors++;
                end
            end
        end
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles, results stopped arriving", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    // **********************************************************
    // Stimulus tasks
    // **********************************************************

    task automatic write_reg(input logic [mac_pkg::CFG_ADDR_W-1:0] addr,
                             input logic [mac_pkg::CFG_DATA_W-1:0] data);
        @(posedge clk);
        sample_valid <= 1'b0;
        cfg_we       <= 1'b1;
        cfg_addr     <= addr;
        cfg_wdata    <= data;
        @(posedge clk);
        cfg_we       <= 1'b0;
    endtask

    task automatic configure(input logic approx, input mac_pkg::count_t count);
        write_reg(mac_pkg::ADDR_MODE, {7'b0, approx});
        write_reg(mac_pkg::ADDR_COUNT, count);
        cur_approx = approx;
    endtask

    task automatic check_reg(input logic [mac_pkg::CFG_ADDR_W-1:0] addr,
                             input logic [mac_pkg::CFG_DATA_W-1:0] want);
        @(posedge clk);
        cfg_addr <= addr;
        @(negedge clk);
        checks++;
        assert (cfg_rdata === want) else begin
            $display("MISMATCH at %0t: address %0d reads %0d, expected %0d",
                     $time, addr, cfg_rdata, want);
            errors++;
        end
    endtask

    task automatic send_sample(input mac_pkg::operand_t x, input mac_pkg::operand_t y,
                               input logic last);
        @(posedge clk);
        sample_valid <= 1'b1;
        a            <= x;
        b            <= y;
        run_sum = dot_step(run_sum, x, y, cur_approx);
        if (last) begin
            expected_q.push_back(run_sum);
            run_sum = '0;
        end
    endtask

    task automatic random_groups(input int groups, input int len);
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        for (int g = 0; g < groups; g++) begin
            for (int s = 0; s < len; s++) begin
                rnd_a = $random(seed);
                rnd_b = $random(seed);
                send_sample(rnd_a[15:0], rnd_b[15:0], s == len - 1);
            end
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        sample_valid <= 1'b0;
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        $display("%-16s %0d checks, %0d failed", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // **********************************************************
    // Test sequence
    // **********************************************************

    initial begin
        int                lat;
        mac_pkg::operand_t corner [4];
        rst_n        = 1'b0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        sample_valid = 1'b0;
        a            = '0;
        b            = '0;
        corner       = '{16'h8000, 16'h7fff, 16'h0000, 16'hffff};
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        checks++;
        assert (result_valid === 1'b0) else begin
            $display("MISMATCH at %0t: result_valid high after reset", $time);
            errors++;
        end
        check_reg(mac_pkg::ADDR_MODE, 8'd0);
        check_reg(mac_pkg::ADDR_COUNT, 8'd1);
        check_reg(2'd3, 8'd0);
        write_reg(mac_pkg::ADDR_MODE, 8'h01);
        write_reg(mac_pkg::ADDR_COUNT, 8'd9);
        write_reg(2'd2, 8'h5a);
        check_reg(mac_pkg::ADDR_MODE, 8'd1);
        check_reg(mac_pkg::ADDR_COUNT, 8'd9);
        check_reg(2'd2, 8'd0);
        finish_test("reset_regs");

        configure(1'b0, 8'd4);
        random_groups(8, 4);
        finish_test("exact_mode");

        configure(1'b1, 8'd4);
        random_groups(8, 4);
        // Single products exercise the multiplier on its own
        configure(1'b1, 8'd1);
        random_groups(20, 1);
        finish_test("approx_mode");

        for (int m = 0; m < 2; m++) begin
            configure(m == 1, 8'd1);
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    send_sample(corner[i], corner[j], 1'b1);
                end
            end
        end
        finish_test("corner_operands");

        // Longest group at full scale
        configure(1'b0, 8'd1);
        random_groups(1, 1);
        configure(1'b0, 8'd7);
        random_groups(1, 7);
        configure(1'b0, 8'd255);
        for (int s = 0; s < 255; s++) begin
            send_sample(16'sh8000, 16'sh8000, s == 254);
        end
        finish_test("length_change");

        // Counted from the edge that takes the sample
        configure(1'b1, 8'd1);
        send_sample(16'sh1234, -16'sd77, 1'b1);
        @(posedge clk);
        sample_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!result_valid && lat < 8);
        checks++;
        assert (lat == 3) else begin
            $display("MISMATCH at %0t: result_valid after %0d cycles, expected 3", $time, lat);
            errors++;
        end
        finish_test("latency");

        $display("Totals %0d checks, %0d failed", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
